// File: rtl/display_config.svh
////////////////////
// display build parameters
// digit count, scan timing and register map
////////////////////
`ifndef DISPLAY_CONFIG_SVH
`define DISPLAY_CONFIG_SVH

`define DISP_DIGITS 4
`define DISP_SHOW_TICKS 32 // cycles each digit is lit
`define DISP_BLANK_TICKS 4 // dark gap ahead of every digit

`define DISP_ADDR_VALUE 12'h000
`define DISP_ADDR_DP 12'h004
`define DISP_ADDR_CTRL 12'h008

`endif

// File: rtl/apb_pkg.sv
////////////////////
// apb_pkg
// APB address and data types
////////////////////
package apb_pkg;

	typedef logic [11:0] apb_addr_t; // byte address
	typedef logic [31:0] apb_data_t;

endpackage

// File: rtl/display_pkg.sv
////////////////////
// display_pkg
// display vector types and scan states
////////////////////
`include "display_config.svh"

package display_pkg;

	localparam int DIGIT_BITS = (`DISP_DIGITS > 1) ? $clog2(`DISP_DIGITS) : 1;

	typedef logic [3:0] nybble_t;
	typedef logic [4*`DISP_DIGITS-1:0] value_t; // digit 0 in the low nybble
	typedef logic [`DISP_DIGITS-1:0] dp_t;
	typedef logic [DIGIT_BITS-1:0] digit_index_t;
	typedef logic [7:0] segment_t; // a in bit 0, dp in bit 7, 1 = lit

	typedef enum logic [1:0] {
		scan_off,
		scan_blank,
		scan_show
	} scan_state_t;

endpackage

// File: rtl/display_regs.sv
////////////////////
// display_regs
// APB slave with value, dp and control registers
////////////////////
`timescale 1ns/10ps
`include "display_config.svh"

module display_regs (
	input logic clock,
	input logic reset,
	input apb_pkg::apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output display_pkg::value_t value,
	output display_pkg::dp_t dp,
	output logic enable,
	output logic blank_all
);
	import apb_pkg::*;
	import display_pkg::*;

	logic access;
	logic hit_value;
	logic hit_dp;
	logic hit_ctrl;

	assign access = psel && penable; // access phase, no wait states
	assign hit_value = (paddr == `DISP_ADDR_VALUE);
	assign hit_dp = (paddr == `DISP_ADDR_DP);
	assign hit_ctrl = (paddr == `DISP_ADDR_CTRL);

	assign pready = 1'b1;
	assign pslverr = access && !(hit_value || hit_dp || hit_ctrl);

	always_ff @(posedge clock) begin
		if (reset) begin
			value <= '0;
			dp <= '0;
			enable <= 1'b0;
			blank_all <= 1'b0;
		end else if (access && pwrite) begin
			if (hit_value) begin
				value <= pwdata[$bits(value_t)-1:0];
			end
			if (hit_dp) begin
				dp <= pwdata[$bits(dp_t)-1:0];
			end
			if (hit_ctrl) begin
				enable <= pwdata[0];
				blank_all <= pwdata[1];
			end
		end
	end

	// read mux, unknown addresses read as zero
	always_comb begin
		prdata = '0;
		if (access) begin
			if (hit_value) begin
				prdata = apb_data_t'(value);
			end else if (hit_dp) begin
				prdata = apb_data_t'(dp);
			end else if (hit_ctrl) begin
				prdata = apb_data_t'({blank_all, enable});
			end
		end
	end

	// an error response only ever closes a proper setup/access pair
	a_slverr_in_access: assert property (@(posedge clock) disable iff (reset)
		pslverr |-> psel && penable && $past(psel && !penable));

endmodule

// File: rtl/digit_scanner.sv
////////////////////
// digit_scanner
// blank/show scan FSM and digit index
////////////////////
`timescale 1ns/10ps
`include "display_config.svh"

module digit_scanner (
	input logic clock,
	input logic reset,
	input logic enable,
	output display_pkg::scan_state_t state,
	output display_pkg::digit_index_t digit,
	output logic load
);
	import display_pkg::*;

	localparam int MAX_TICKS = (`DISP_SHOW_TICKS > `DISP_BLANK_TICKS) ?
		`DISP_SHOW_TICKS : `DISP_BLANK_TICKS;
	localparam int COUNT_BITS = (MAX_TICKS > 1) ? $clog2(MAX_TICKS) : 1;

	logic [COUNT_BITS-1:0] count; // cycles left in the current phase

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= scan_off;
			digit <= '0;
			count <= '0;
			load <= 1'b0;
		end else begin
			load <= 1'b0;
			if (!enable) begin
				state <= scan_off;
				digit <= '0;
				count <= '0;
			end else begin
				case (state)
					scan_off: begin
						state <= scan_blank; // scan always starts on digit 0
						digit <= '0;
						count <= COUNT_BITS'(`DISP_BLANK_TICKS - 1);
					end
					scan_blank: begin
						if (count == '0) begin
							state <= scan_show;
							count <= COUNT_BITS'(`DISP_SHOW_TICKS - 1);
							load <= 1'b1; // encoder grabs the digit
						end else begin
							count <= count - 1'b1;
						end
					end
					default: begin
						if (count == '0) begin
							state <= scan_blank;
							count <= COUNT_BITS'(`DISP_BLANK_TICKS - 1);
							if (digit == digit_index_t'(`DISP_DIGITS - 1)) begin
								digit <= '0;
							end else begin
								digit <= digit + 1'b1;
							end
						end else begin
							count <= count - 1'b1;
						end
					end
				endcase
			end
		end
	end

	a_load_in_show: assert property (@(posedge clock) disable iff (reset)
		load |-> state == scan_show && $past(state) == scan_blank);
	a_digit_range: assert property (@(posedge clock) disable iff (reset)
		digit < `DISP_DIGITS);

endmodule

// File: rtl/segment_encoder.sv
////////////////////
// segment_encoder
// digit select and hex font
////////////////////
`timescale 1ns/10ps

module segment_encoder (
	input logic clock,
	input logic reset,
	input display_pkg::value_t value,
	input display_pkg::dp_t dp,
	input display_pkg::digit_index_t digit,
	input logic load,
	output display_pkg::segment_t segments
);
	import display_pkg::*;

	nybble_t nybble;

	// gfedcba, 1 = lit
	function automatic logic [6:0] hex_font(input nybble_t n);
		case (n)
			4'h0: hex_font = 7'h3f;
			4'h1: hex_font = 7'h06;
			4'h2: hex_font = 7'h5b;
			4'h3: hex_font = 7'h4f;
			4'h4: hex_font = 7'h66;
			4'h5: hex_font = 7'h6d;
			4'h6: hex_font = 7'h7d;
			4'h7: hex_font = 7'h07;
			4'h8: hex_font = 7'h7f;
			4'h9: hex_font = 7'h6f;
			4'ha: hex_font = 7'h77;
			4'hb: hex_font = 7'h7c; // lower case b
			4'hc: hex_font = 7'h39;
			4'hd: hex_font = 7'h5e; // lower case d
			4'he: hex_font = 7'h79;
			default: hex_font = 7'h71;
		endcase
	endfunction

	assign nybble = value[4*digit +: 4];

	always_ff @(posedge clock) begin
		if (reset) begin
			segments <= '0;
		end else if (load) begin
			segments <= {dp[digit], hex_font(nybble)}; // held for the whole slot
		end
	end

endmodule

// File: rtl/display_outputs.sv
////////////////////
// display_outputs
// active-low pin registers and frame sync
////////////////////
`timescale 1ns/10ps
`include "display_config.svh"

module display_outputs (
	input logic clock,
	input logic reset,
	input display_pkg::scan_state_t state,
	input display_pkg::digit_index_t digit,
	input display_pkg::segment_t segments,
	input logic blank_all,
	output display_pkg::segment_t cathode,
	output logic [`DISP_DIGITS-1:0] anode,
	output logic frame_sync
);
	import display_pkg::*;

	scan_state_t state_d; // lined up with segments
	digit_index_t digit_d;
	logic lit;
	logic [`DISP_DIGITS-1:0] anode_next;

	assign lit = (state_d == scan_show) && !blank_all;

	always_comb begin
		anode_next = '1;
		if (lit) begin
			anode_next[digit_d] = 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_d <= scan_off;
			digit_d <= '0;
			anode <= '1;
			cathode <= '1;
			frame_sync <= 1'b0;
		end else begin
			state_d <= state;
			digit_d <= digit;
			anode <= anode_next;
			cathode <= lit ? ~segments : '1; // dark whenever no digit is driven
			frame_sync <= !anode_next[0] && anode[0]; // digit 0 turning on
		end
	end

	a_one_anode: assert property (@(posedge clock) disable iff (reset)
		$onehot0(~anode));

endmodule

// File: rtl/display_top.sv
////////////////////
// display_top
// APB seven-segment display controller
////////////////////
`timescale 1ns/10ps
`include "display_config.svh"

module display_top (
	input logic clock,
	input logic reset,
	input apb_pkg::apb_addr_t paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apb_pkg::apb_data_t pwdata,
	output apb_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	output display_pkg::segment_t cathode,
	output logic [`DISP_DIGITS-1:0] anode,
	output logic frame_sync
);
	import display_pkg::*;

	value_t value;
	dp_t dp;
	logic enable;
	logic blank_all;
	scan_state_t state;
	digit_index_t digit;
	logic load;
	segment_t segments;

	display_regs regs (.clock(clock), .reset(reset), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .value(value), .dp(dp), .enable(enable),
		.blank_all(blank_all));

	digit_scanner scanner (.clock(clock), .reset(reset), .enable(enable),
		.state(state), .digit(digit), .load(load));

	segment_encoder encoder (.clock(clock), .reset(reset), .value(value), .dp(dp),
		.digit(digit), .load(load), .segments(segments));

	display_outputs outputs (.clock(clock), .reset(reset), .state(state),
		.digit(digit), .segments(segments), .blank_all(blank_all),
		.cathode(cathode), .anode(anode), .frame_sync(frame_sync));

endmodule

// File: tb/tb_clock.sv
////////////////////
// testbench clock source, 4 ns period
////////////////////
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS = 4
) (
	output logic clock
);
	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end
endmodule

// File: tb/display_tb.sv
////////////////////
// display controller testbench
// APB driver, register and font model, pin monitor, watchdog
////////////////////
`timescale 1ns/10ps
`include "display_config.svh"

module display_tb;
	import apb_pkg::*;
	import display_pkg::*;

	localparam int SLOT = `DISP_SHOW_TICKS + `DISP_BLANK_TICKS;
	localparam int FRAME = `DISP_DIGITS * SLOT;
	localparam int NUM_VALUES = 20;
	localparam int TEST_ROUNDS = 2 * NUM_VALUES + 6; // each display value spans two frame rounds
	localparam int WATCHDOG_NS = TEST_ROUNDS * (`DISP_DIGITS + 2) * SLOT * 4 + 2000;
	localparam logic [`DISP_DIGITS-1:0] ALL_OFF = {`DISP_DIGITS{1'b1}};
	// gfedcba, 1 = lit
	localparam logic [6:0] FONT [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
		7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic clock;
	logic reset;
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic pready;
	logic pslverr;
	segment_t cathode;
	logic [`DISP_DIGITS-1:0] anode;
	logic frame_sync;

	value_t value_sh; // shadow registers
	dp_t dp_sh;
	logic [1:0] ctrl_sh;
	logic [31:0] rng;
	int errors;
	int start_errors;
	int frame_pulses;
	logic dark_check; // monitor modes, set by the tests
	logic digit_check;
	logic timing_check;
	logic [`DISP_DIGITS-1:0] anode_prev;
	int run_len;
	int edges_seen;
	int last_digit;
	logic last_valid;
	apb_addr_t bad_addr;

	tb_clock clock_gen (.clock(clock));

	display_top dut (.clock(clock), .reset(reset), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .cathode(cathode), .anode(anode),
		.frame_sync(frame_sync));

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic known_addr(input apb_addr_t a);
		return a == `DISP_ADDR_VALUE || a == `DISP_ADDR_DP || a == `DISP_ADDR_CTRL;
	endfunction

	// index of the low anode, -1 when dark
	function automatic int lit_digit(input logic [`DISP_DIGITS-1:0] a);
		int i;
		lit_digit = -1;
		for (i = 0; i < `DISP_DIGITS; i++) begin
			if (!a[i]) lit_digit = i;
		end
	endfunction

	function automatic segment_t expected_cathode(input int k);
		return ~{dp_sh[k], FONT[value_sh[4*k +: 4]]};
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic apb_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		@(posedge clock);
		#1;
		psel = 1'b1; // setup cycle
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clock);
		#1;
		penable = 1'b1;
		@(negedge clock);
		compare("pready", pready, 1'b1);
		rdata = prdata;
		err = pslverr;
		@(posedge clock);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic reg_write(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rdata;
		logic err;
		apb_transfer(1'b1, addr, data, rdata, err);
		compare("pslverr", err, !known_addr(addr));
		case (addr)
			`DISP_ADDR_VALUE: value_sh = data[$bits(value_t)-1:0];
			`DISP_ADDR_DP: dp_sh = data[$bits(dp_t)-1:0];
			`DISP_ADDR_CTRL: ctrl_sh = data[1:0];
			default: ; // ignored by the slave
		endcase
	endtask

	task automatic reg_read_check(input apb_addr_t addr);
		apb_data_t rdata;
		apb_data_t expected;
		logic err;
		apb_transfer(1'b0, addr, '0, rdata, err);
		case (addr)
			`DISP_ADDR_VALUE: expected = apb_data_t'(value_sh);
			`DISP_ADDR_DP: expected = apb_data_t'(dp_sh);
			`DISP_ADDR_CTRL: expected = apb_data_t'(ctrl_sh);
			default: expected = '0;
		endcase
		compare("prdata", rdata, expected);
		compare("pslverr", err, !known_addr(addr));
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d errors", name, errors - start_errors);
		start_errors = errors;
	endtask

	// pin monitor, samples mid-cycle
	always @(negedge clock) begin
		int k;
		logic lit_now;
		logic lit_prev;
		k = lit_digit(anode);
		if (!reset) begin
			assert ($onehot0(~anode)) else begin
				$display("%0t ns: more than one anode driven low (%b)", $time, anode);
				errors++;
			end
			compare("frame_sync", frame_sync, anode_prev[0] && !anode[0]);
			if (frame_sync) frame_pulses++;
			if (dark_check) begin
				compare("anode", anode, ALL_OFF);
				compare("cathode", cathode, 8'hff);
				compare("frame_sync", frame_sync, 1'b0);
			end
			if (digit_check && k >= 0) compare("cathode", cathode, expected_cathode(k));
			if (timing_check) begin
				lit_now = (k >= 0);
				lit_prev = (anode_prev != ALL_OFF);
				if (lit_now != lit_prev) begin
					if (edges_seen > 0) begin
						compare(lit_prev ? "anode low cycles" : "anode high cycles", run_len,
							lit_prev ? `DISP_SHOW_TICKS : `DISP_BLANK_TICKS);
					end
					if (lit_now && last_valid) begin
						compare("lit digit", k, (last_digit + 1) % `DISP_DIGITS);
					end
					if (lit_now) begin
						last_digit = k;
						last_valid = 1'b1;
					end
					edges_seen++;
					run_len = 1;
				end else begin
					run_len++;
					if (lit_now) compare("anode", anode, anode_prev); // same digit all slot
				end
			end else begin
				edges_seen = 0;
				last_valid = 1'b0;
				run_len = 0;
			end
		end
		anode_prev = anode;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t ns, the tests did not finish", $time);
		$display("Checks failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		value_sh = '0;
		dp_sh = '0;
		ctrl_sh = '0;
		rng = 32'hf721_447f;
		errors = 0;
		start_errors = 0;
		frame_pulses = 0;
		dark_check = 1'b0;
		digit_check = 1'b0;
		timing_check = 1'b0;
		anode_prev = ALL_OFF;
		repeat (16) @(posedge clock);
		#1 reset = 1'b0;

		dark_check = 1'b1; // nothing lit before enable
		repeat (FRAME) @(posedge clock);
		dark_check = 1'b0;
		end_test("test 1 after reset");

		repeat (8) begin
			rng = xorshift(rng);
			reg_write(`DISP_ADDR_VALUE, rng);
			rng = xorshift(rng);
			reg_write(`DISP_ADDR_DP, rng);
			rng = xorshift(rng);
			reg_write(`DISP_ADDR_CTRL, rng);
			rng = xorshift(rng);
			bad_addr = rng[11:0];
			if (known_addr(bad_addr)) bad_addr = bad_addr + 12'h010;
			reg_write(bad_addr, xorshift(rng));
			reg_read_check(`DISP_ADDR_VALUE);
			reg_read_check(`DISP_ADDR_DP);
			reg_read_check(`DISP_ADDR_CTRL);
			reg_read_check(bad_addr);
		end
		end_test("test 2 register readback");

		repeat (NUM_VALUES) begin
			rng = xorshift(rng);
			reg_write(`DISP_ADDR_VALUE, rng);
			rng = xorshift(rng);
			reg_write(`DISP_ADDR_DP, rng);
			reg_write(`DISP_ADDR_CTRL, 32'h1);
			repeat (FRAME + 4) @(posedge clock); // every digit reloads
			digit_check = 1'b1;
			repeat (FRAME) @(posedge clock);
			digit_check = 1'b0;
		end
		end_test("test 3 displayed digits");

		timing_check = 1'b1;
		repeat (3 * FRAME) @(posedge clock);
		assert (edges_seen >= 4 * `DISP_DIGITS) else begin
			$display("%0t ns: scan stalled, only %0d anode changes seen", $time, edges_seen);
			errors++;
		end
		timing_check = 1'b0;
		end_test("test 4 scan order and timing");

		frame_pulses = 0;
		repeat (3 * FRAME) @(posedge clock);
		compare("frame_sync pulses", frame_pulses, 3);
		end_test("test 5 frame sync");

		reg_write(`DISP_ADDR_CTRL, 32'h3);
		repeat (2) @(posedge clock);
		dark_check = 1'b1;
		repeat (FRAME) @(posedge clock);
		dark_check = 1'b0;
		reg_write(`DISP_ADDR_CTRL, 32'h1);
		repeat (FRAME) @(posedge clock);
		reg_write(`DISP_ADDR_CTRL, 32'h0);
		repeat (3) @(posedge clock); // scanner off, then two pipeline stages
		dark_check = 1'b1;
		repeat (2 * FRAME) @(posedge clock);
		dark_check = 1'b0;
		end_test("test 6 blanking and disable");

		$display("6 tests run, %0d errors", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+rtl
rtl/apb_pkg.sv
rtl/display_pkg.sv
rtl/display_regs.sv
rtl/digit_scanner.sv
rtl/segment_encoder.sv
rtl/display_outputs.sv
rtl/display_top.sv
tb/tb_clock.sv
tb/display_tb.sv

// File: run.sh
#!/bin/sh
# builds the display controller testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module display_tb \
	-f src.f -o display_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/display_sim > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && exit 1 || exit 0
